// File: rtl/cmo_pkg.sv
// Cache maintenance handler shared definitions
// Geometry, vector types and the operation and state encodings
package cmo_pkg;

    // Cache geometry
    localparam int CMO_SETS     = 4;
    localparam int CMO_WAYS     = 2;
    localparam int CMO_ADDR_W   = 32;
    localparam int CMO_OFFSET_W = 6;
    localparam int CMO_TID_W    = 4;

    // Derived widths
    localparam int CMO_SET_W   = $clog2(CMO_SETS);
    localparam int CMO_NLINE_W = CMO_ADDR_W - CMO_OFFSET_W;
    localparam int CMO_TAG_W   = CMO_NLINE_W - CMO_SET_W;

    typedef logic [CMO_ADDR_W-1:0]  addr_t;
    typedef logic [CMO_SET_W-1:0]   set_t;
    typedef logic [CMO_TAG_W-1:0]   tag_t;
    typedef logic [CMO_NLINE_W-1:0] nline_t;
    typedef logic [CMO_WAYS-1:0]    way_vec_t;
    typedef logic [CMO_TID_W-1:0]   tid_t;

    typedef enum logic [1:0] {
        CMO_FENCE,
        CMO_INVAL_NLINE,
        CMO_INVAL_ALL,
        CMO_FLUSH_ALL
    } cmo_op_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FENCE_WAIT,
        ST_WAIT_EMPTY,
        ST_INVAL_CHECK,
        ST_INVAL_SET,
        ST_FLUSH_WALK,
        ST_FLUSH_DRAIN
    } cmo_state_t;

endpackage

// File: rtl/cmo_set_way_walker.sv
// Set and way walker for the whole-cache operations
// One-hot way pointer, set index moves on when the way wraps
module cmo_set_way_walker (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                start_i,
    input  logic                step_i,
    output cmo_pkg::set_t       set_o,
    output cmo_pkg::way_vec_t   way_o,
    output logic                done_o
);
    import cmo_pkg::*;

    set_t     set_q;
    way_vec_t way_q;
    logic     way_last;

    assign way_last = way_q[CMO_WAYS-1];
    assign set_o    = set_q;
    assign way_o    = way_q;
    assign done_o   = way_last && (set_q == set_t'(CMO_SETS - 1));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            set_q <= '0;
            way_q <= way_vec_t'(1);
        end else if (start_i && step_i) begin
            // Set stride, used when the ways are not walked
            set_q <= set_q + 1'b1;
            way_q <= way_vec_t'(1);
        end else if (start_i) begin
            set_q <= '0;
            way_q <= way_vec_t'(1);
        end else if (step_i) begin
            way_q <= way_last ? way_vec_t'(1) : {way_q[CMO_WAYS-2:0], 1'b0};
            if (way_last) begin
                set_q <= set_q + 1'b1;
            end
        end
    end

endmodule

// File: rtl/cmo_flush_queue.sv
// Write-back request FIFO towards the flush controller
module cmo_flush_queue #(
    parameter int FLUSH_FIFO_DEPTH = 3
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                push_i,
    input  cmo_pkg::nline_t     push_nline_i,
    input  cmo_pkg::way_vec_t   push_way_i,
    output logic                room_o,
    output logic                empty_o,
    input  logic                pop_ready_i,
    output logic                valid_o,
    output cmo_pkg::nline_t     nline_o,
    output cmo_pkg::way_vec_t   way_o
);
    import cmo_pkg::*;

    localparam int PTR_W = $clog2(FLUSH_FIFO_DEPTH);
    localparam int CNT_W = $clog2(FLUSH_FIFO_DEPTH + 1);

    nline_t           nline_mem [FLUSH_FIFO_DEPTH];
    way_vec_t         way_mem   [FLUSH_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FLUSH_FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign valid_o = (count_q != '0);
    assign empty_o = !valid_o;
    assign pop     = valid_o && pop_ready_i;
    assign nline_o = nline_mem[rd_ptr_q];
    assign way_o   = way_mem[rd_ptr_q];

    // Two free slots: one result being written, one check still in flight
    assign room_o = (count_q <= CNT_W'(FLUSH_FIFO_DEPTH - 2));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            if (push_i && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            nline_mem[wr_ptr_q] <= push_nline_i;
            way_mem[wr_ptr_q]   <= push_way_i;
        end
    end

endmodule

// File: rtl/cmo_sequencer.sv
// Maintenance request sequencer
// Drives the directory strobes, the fence and the held core response
module cmo_sequencer (
    input  logic                clk_i,
    input  logic                rst_ni,

    input  logic                wbuf_empty_i,
    input  logic                mshr_empty_i,
    input  logic                rtab_empty_i,

    input  logic                req_valid_i,
    output logic                req_ready_o,
    input  cmo_pkg::cmo_op_t    req_op_i,
    input  cmo_pkg::addr_t      req_addr_i,
    input  cmo_pkg::tid_t       req_tid_i,
    input  logic                req_need_rsp_i,
    output logic                req_wait_o,

    input  logic                core_rsp_ready_i,
    output logic                core_rsp_valid_o,
    output cmo_pkg::tid_t       core_rsp_tid_o,

    output logic                wbuf_flush_all_o,

    output logic                dir_check_nline_o,
    output cmo_pkg::set_t       dir_check_nline_set_o,
    output cmo_pkg::tag_t       dir_check_nline_tag_o,
    input  cmo_pkg::way_vec_t   dir_check_nline_hit_way_i,
    input  logic                dir_check_nline_dirty_i,

    output logic                dir_check_entry_o,
    output cmo_pkg::set_t       dir_check_entry_set_o,
    output cmo_pkg::way_vec_t   dir_check_entry_way_o,
    input  logic                dir_check_entry_valid_i,
    input  logic                dir_check_entry_dirty_i,
    input  cmo_pkg::tag_t       dir_check_entry_tag_i,

    output logic                dir_inval_o,
    output cmo_pkg::set_t       dir_inval_set_o,
    output cmo_pkg::way_vec_t   dir_inval_way_o,

    output logic                walk_start_o,
    output logic                walk_step_o,
    input  cmo_pkg::set_t       walk_set_i,
    input  cmo_pkg::way_vec_t   walk_way_i,
    input  logic                walk_done_i,

    output logic                fq_push_o,
    output cmo_pkg::nline_t     fq_nline_o,
    output cmo_pkg::way_vec_t   fq_way_o,
    input  logic                fq_room_i,
    input  logic                fq_empty_i
);
    import cmo_pkg::*;

    cmo_state_t state_q, state_d;
    cmo_op_t    op_q;
    nline_t     nline_q;
    tid_t       rsp_tid_q;
    logic       need_rsp_q;
    logic       rsp_valid_q, rsp_valid_d;

    // Last entry check, its result arrives one cycle later
    logic       pend_valid_q, pend_valid_d;
    set_t       pend_set_q;
    way_vec_t   pend_way_q;

    logic       accept;
    logic       tables_empty;
    logic       finish;
    set_t       line_set;
    tag_t       line_tag;

    // First working state of an operation once the tables are empty
    function automatic cmo_state_t op_state(cmo_op_t op);
        case (op)
            CMO_INVAL_NLINE: return ST_INVAL_CHECK;
            CMO_INVAL_ALL:   return ST_INVAL_SET;
            CMO_FLUSH_ALL:   return ST_FLUSH_WALK;
            default:         return ST_IDLE;
        endcase
    endfunction

    assign line_set     = nline_q[CMO_SET_W-1:0];
    assign line_tag     = nline_q[CMO_NLINE_W-1:CMO_SET_W];
    assign tables_empty = mshr_empty_i && rtab_empty_i;

    assign req_ready_o = (state_q == ST_IDLE) && (!rsp_valid_q || core_rsp_ready_i);
    assign accept      = req_valid_i && req_ready_o;
    assign req_wait_o  = (state_q == ST_FENCE_WAIT) || (state_q == ST_WAIT_EMPTY);

    assign core_rsp_valid_o = rsp_valid_q;
    assign core_rsp_tid_o   = rsp_tid_q;

    assign dir_check_nline_set_o = line_set;
    assign dir_check_nline_tag_o = line_tag;
    assign dir_check_entry_set_o = walk_set_i;
    assign dir_check_entry_way_o = walk_way_i;

    // Valid dirty entries go to the write-back queue with the directory tag
    assign fq_push_o  = pend_valid_q && dir_check_entry_valid_i && dir_check_entry_dirty_i;
    assign fq_nline_o = {dir_check_entry_tag_i, pend_set_q};
    assign fq_way_o   = pend_way_q;

    always_comb begin
        state_d           = state_q;
        rsp_valid_d       = rsp_valid_q && !core_rsp_ready_i;
        pend_valid_d      = 1'b0;
        finish            = 1'b0;
        wbuf_flush_all_o  = 1'b0;
        walk_start_o      = accept;
        walk_step_o       = 1'b0;
        dir_check_nline_o = 1'b0;
        dir_check_entry_o = 1'b0;
        dir_inval_o       = 1'b0;
        dir_inval_set_o   = line_set;
        dir_inval_way_o   = '0;

        case (state_q)
            ST_IDLE: begin
                if (accept) begin
                    if (req_op_i == CMO_FENCE) begin
                        // Open write buffer entries are pushed out first
                        wbuf_flush_all_o = rtab_empty_i;
                        if (wbuf_empty_i && rtab_empty_i) begin
                            rsp_valid_d = req_need_rsp_i;
                        end else begin
                            state_d = ST_FENCE_WAIT;
                        end
                    end else if (tables_empty) begin
                        state_d = op_state(req_op_i);
                    end else begin
                        state_d = ST_WAIT_EMPTY;
                    end
                end
            end
            ST_FENCE_WAIT: begin
                wbuf_flush_all_o = rtab_empty_i;
                finish           = wbuf_empty_i && rtab_empty_i;
            end
            ST_WAIT_EMPTY: begin
                if (tables_empty) begin
                    state_d = op_state(op_q);
                end
            end
            ST_INVAL_CHECK: begin
                dir_check_nline_o = 1'b1;
                state_d           = ST_INVAL_SET;
            end
            ST_INVAL_SET: begin
                if (op_q == CMO_INVAL_NLINE) begin
                    dir_inval_o     = |dir_check_nline_hit_way_i;
                    dir_inval_way_o = dir_check_nline_hit_way_i;
                    finish          = 1'b1;
                end else begin
                    // One whole set per cycle, walker strides by set
                    dir_inval_o     = 1'b1;
                    dir_inval_set_o = walk_set_i;
                    dir_inval_way_o = '1;
                    walk_start_o    = 1'b1;
                    walk_step_o     = 1'b1;
                    finish          = (walk_set_i == set_t'(CMO_SETS - 1));
                end
            end
            ST_FLUSH_WALK: begin
                // Stall on a full queue so no checked entry gets dropped
                if (fq_room_i) begin
                    dir_check_entry_o = 1'b1;
                    pend_valid_d      = 1'b1;
                    if (walk_done_i) begin
                        state_d = ST_FLUSH_DRAIN;
                    end else begin
                        walk_step_o = 1'b1;
                    end
                end
            end
            ST_FLUSH_DRAIN: begin
                finish = !pend_valid_q && fq_empty_i;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase

        if (finish) begin
            state_d     = ST_IDLE;
            rsp_valid_d = need_rsp_q;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q      <= ST_IDLE;
            rsp_valid_q  <= 1'b0;
            pend_valid_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            rsp_valid_q  <= rsp_valid_d;
            pend_valid_q <= pend_valid_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            op_q       <= req_op_i;
            nline_q    <= req_addr_i[CMO_OFFSET_W +: CMO_NLINE_W];
            rsp_tid_q  <= req_tid_i;
            need_rsp_q <= req_need_rsp_i;
        end
        if (dir_check_entry_o) begin
            pend_set_q <= walk_set_i;
            pend_way_q <= walk_way_i;
        end
    end

endmodule

// File: rtl/cmo_top.sv
// Cache maintenance operation handler
// Sequencer, set/way walker and write-back request queue
module cmo_top #(
    parameter int FLUSH_FIFO_DEPTH = 3
) (
    input  logic                clk_i,
    input  logic                rst_ni,

    input  logic                wbuf_empty_i,
    input  logic                mshr_empty_i,
    input  logic                rtab_empty_i,

    input  logic                req_valid_i,
    output logic                req_ready_o,
    input  cmo_pkg::cmo_op_t    req_op_i,
    input  cmo_pkg::addr_t      req_addr_i,
    input  cmo_pkg::tid_t       req_tid_i,
    input  logic                req_need_rsp_i,
    output logic                req_wait_o,

    input  logic                core_rsp_ready_i,
    output logic                core_rsp_valid_o,
    output cmo_pkg::tid_t       core_rsp_tid_o,

    output logic                wbuf_flush_all_o,

    output logic                dir_check_nline_o,
    output cmo_pkg::set_t       dir_check_nline_set_o,
    output cmo_pkg::tag_t       dir_check_nline_tag_o,
    input  cmo_pkg::way_vec_t   dir_check_nline_hit_way_i,
    input  logic                dir_check_nline_dirty_i,

    output logic                dir_check_entry_o,
    output cmo_pkg::set_t       dir_check_entry_set_o,
    output cmo_pkg::way_vec_t   dir_check_entry_way_o,
    input  logic                dir_check_entry_valid_i,
    input  logic                dir_check_entry_dirty_i,
    input  cmo_pkg::tag_t       dir_check_entry_tag_i,

    output logic                dir_inval_o,
    output cmo_pkg::set_t       dir_inval_set_o,
    output cmo_pkg::way_vec_t   dir_inval_way_o,

    output logic                flush_alloc_o,
    input  logic                flush_alloc_ready_i,
    output cmo_pkg::nline_t     flush_alloc_nline_o,
    output cmo_pkg::way_vec_t   flush_alloc_way_o
);
    import cmo_pkg::*;

    logic     walk_start;
    logic     walk_step;
    set_t     walk_set;
    way_vec_t walk_way;
    logic     walk_done;

    logic     fq_push;
    nline_t   fq_nline;
    way_vec_t fq_way;
    logic     fq_room;
    logic     fq_empty;

    // Request, directory and response ports share the top-level names
    cmo_sequencer u_sequencer (
        .*,
        .walk_start_o (walk_start),
        .walk_step_o  (walk_step),
        .walk_set_i   (walk_set),
        .walk_way_i   (walk_way),
        .walk_done_i  (walk_done),
        .fq_push_o    (fq_push),
        .fq_nline_o   (fq_nline),
        .fq_way_o     (fq_way),
        .fq_room_i    (fq_room),
        .fq_empty_i   (fq_empty)
    );

    cmo_set_way_walker u_walker (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .start_i (walk_start),
        .step_i  (walk_step),
        .set_o   (walk_set),
        .way_o   (walk_way),
        .done_o  (walk_done)
    );

    cmo_flush_queue #(
        .FLUSH_FIFO_DEPTH (FLUSH_FIFO_DEPTH)
    ) u_flush_queue (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .push_i       (fq_push),
        .push_nline_i (fq_nline),
        .push_way_i   (fq_way),
        .room_o       (fq_room),
        .empty_o      (fq_empty),
        .pop_ready_i  (flush_alloc_ready_i),
        .valid_o      (flush_alloc_o),
        .nline_o      (flush_alloc_nline_o),
        .way_o        (flush_alloc_way_o)
    );

endmodule

// File: testbench/tb_cmo_assertions.sv
// Handshake checks bound into the cache maintenance handler top level
module tb_cmo_assertions (
    input logic                 clk_i,
    input logic                 rst_ni,
    input logic                 mshr_empty_i,
    input logic                 rtab_empty_i,
    input logic                 req_valid_i,
    input logic                 req_ready_o,
    input cmo_pkg::cmo_op_t     req_op_i,
    input logic                 req_wait_o,
    input logic                 core_rsp_valid_o,
    input logic                 core_rsp_ready_i,
    input cmo_pkg::tid_t        core_rsp_tid_o,
    input logic                 flush_alloc_o,
    input logic                 flush_alloc_ready_i,
    input cmo_pkg::nline_t      flush_alloc_nline_o,
    input cmo_pkg::way_vec_t    flush_alloc_way_o,
    input logic                 dir_check_nline_o,
    input logic                 dir_inval_o,
    input logic                 dir_check_entry_o,
    input cmo_pkg::cmo_state_t  state_i
);
    import cmo_pkg::*;

    int fail_count = 0;

    flush_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_alloc_o && !flush_alloc_ready_i |=>
            flush_alloc_o && $stable(flush_alloc_nline_o) && $stable(flush_alloc_way_o))
    else begin
        fail_count++;
        $error("flush request changed before it was taken");
    end

    rsp_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        core_rsp_valid_o && !core_rsp_ready_i |=>
            core_rsp_valid_o && $stable(core_rsp_tid_o))
    else begin
        fail_count++;
        $error("core response changed before it was taken");
    end

    // Any accepted operation other than a fence leaves idle
    accept_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        req_valid_i && req_ready_o && (req_op_i != CMO_FENCE) |=> state_i != ST_IDLE)
    else begin
        fail_count++;
        $error("accepted request left the handler idle");
    end

    // Busy tables hold back every directory strobe
    no_strobe_while_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
        req_wait_o && !(mshr_empty_i && rtab_empty_i) |=>
            !(dir_check_nline_o || dir_check_entry_o || dir_inval_o))
    else begin
        fail_count++;
        $error("directory strobed while the miss or replay table was busy");
    end

endmodule

bind cmo_top tb_cmo_assertions u_assertions (
    .*,
    .state_i (u_sequencer.state_q)
);

// File: testbench/tb_cmo.sv
// Testbench for the cache maintenance handler
// Behavioral directory, write buffer and flush controller around the DUT
module tb_cmo;
    import cmo_pkg::*;

    localparam int NUM_ROWS  = 9;
    localparam int TIMEOUT   = 300;
    localparam int PRE_KEEP  = 0;
    localparam int PRE_LINE  = 1;
    localparam int PRE_RAND  = 2;
    localparam int PRE_DIRTY = 3;

    typedef struct {
        string   name;
        cmo_op_t op;
        addr_t   addr;
        tid_t    tid;
        logic    need_rsp;
        int      preload;
        int      wbuf_n;
        int      rtab_n;
        int      mshr_n;
        logic    stall;
        int      exp_invals;
    } row_t;

    logic     clk_i = 1'b0;
    logic     rst_ni;
    logic     wbuf_empty_i, mshr_empty_i, rtab_empty_i;
    logic     req_valid_i, req_ready_o, req_need_rsp_i, req_wait_o;
    cmo_op_t  req_op_i;
    addr_t    req_addr_i;
    tid_t     req_tid_i, core_rsp_tid_o;
    logic     core_rsp_ready_i, core_rsp_valid_o, wbuf_flush_all_o;
    logic     dir_check_nline_o, dir_check_nline_dirty_i;
    set_t     dir_check_nline_set_o, dir_check_entry_set_o, dir_inval_set_o;
    tag_t     dir_check_nline_tag_o, dir_check_entry_tag_i;
    way_vec_t dir_check_nline_hit_way_i, dir_check_entry_way_o, dir_inval_way_o;
    logic     dir_check_entry_o, dir_check_entry_valid_i, dir_check_entry_dirty_i;
    logic     dir_inval_o, flush_alloc_o, flush_alloc_ready_i;
    nline_t   flush_alloc_nline_o;
    way_vec_t flush_alloc_way_o;

    row_t     rows [NUM_ROWS];
    logic     dir_valid [CMO_SETS][CMO_WAYS];
    logic     dir_dirty [CMO_SETS][CMO_WAYS];
    tag_t     dir_tag   [CMO_SETS][CMO_WAYS];
    nline_t   flush_nline_q [$];
    way_vec_t flush_way_q [$];
    set_t     inval_set_q [$];
    way_vec_t inval_way_q [$];
    nline_t   exp_nline_q [$];
    way_vec_t exp_way_q [$];
    int       wbuf_cnt, rtab_cnt, mshr_cnt;
    logic     stall_en, accepted, ready_seen, rsp_seen, early_rsp;
    int       rsp_count, flush_at_rsp, early_strobes, wait_cycles, flush_all_cycles;
    tid_t     rsp_tid;
    int       err_count, timeout_count;

    cmo_top uut (.*);

    always #4 clk_i = ~clk_i;

    task automatic compare(input string test, input string what,
                           input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("error %s %s: expected %0h, actual %0h", test, what, exp, act);
            err_count++;
        end
    endtask

    function automatic logic line_valid(input set_t s, input tag_t t);
        logic found;
        found = 1'b0;
        for (int w = 0; w < CMO_WAYS; w++) begin
            found |= dir_valid[s][w] && (dir_tag[s][w] == t);
        end
        return found;
    endfunction

    function automatic int valid_count();
        int n;
        n = 0;
        for (int s = 0; s < CMO_SETS; s++) begin
            for (int w = 0; w < CMO_WAYS; w++) begin
                n += int'(dir_valid[s][w]);
            end
        end
        return n;
    endfunction

    // One clock of the models, responses go out just after the edge
    task automatic tick();
        way_vec_t hit;
        logic     hit_dirty;
        logic     ent_valid;
        logic     ent_dirty;
        tag_t     ent_tag;
        hit       = '0;
        hit_dirty = 1'b0;
        ent_valid = 1'b0;
        ent_dirty = 1'b0;
        ent_tag   = '0;
        @(posedge clk_i);
        accepted   = req_valid_i && req_ready_o;
        ready_seen = req_ready_o;
        if (core_rsp_valid_o && !rsp_seen) begin
            rsp_seen     = 1'b1;
            flush_at_rsp = flush_nline_q.size();
            early_rsp    = (wbuf_cnt != 0) || (rtab_cnt != 0);
        end
        if (core_rsp_valid_o && core_rsp_ready_i) begin
            rsp_count++;
            rsp_tid = core_rsp_tid_o;
        end
        if (mshr_cnt != 0 && (dir_check_nline_o || dir_check_entry_o || dir_inval_o)) begin
            early_strobes++;
        end
        wait_cycles      += int'(req_wait_o);
        flush_all_cycles += int'(wbuf_flush_all_o);
        for (int w = 0; w < CMO_WAYS; w++) begin
            if (dir_check_nline_o && dir_valid[dir_check_nline_set_o][w]
                && dir_tag[dir_check_nline_set_o][w] == dir_check_nline_tag_o) begin
                hit[w]    = 1'b1;
                hit_dirty |= dir_dirty[dir_check_nline_set_o][w];
            end
            if (dir_check_entry_o && dir_check_entry_way_o[w]) begin
                ent_valid = dir_valid[dir_check_entry_set_o][w];
                ent_dirty = dir_dirty[dir_check_entry_set_o][w];
                ent_tag   = dir_tag[dir_check_entry_set_o][w];
            end
        end
        // Invalidation lands after the reads of the same edge
        if (dir_inval_o) begin
            inval_set_q.push_back(dir_inval_set_o);
            inval_way_q.push_back(dir_inval_way_o);
            for (int w = 0; w < CMO_WAYS; w++) begin
                if (dir_inval_way_o[w]) begin
                    dir_valid[dir_inval_set_o][w] = 1'b0;
                end
            end
        end
        if (flush_alloc_o && flush_alloc_ready_i) begin
            flush_nline_q.push_back(flush_alloc_nline_o);
            flush_way_q.push_back(flush_alloc_way_o);
        end
        if (wbuf_flush_all_o && wbuf_cnt > 0) begin
            wbuf_cnt--;
        end
        if (rtab_cnt > 0) begin
            rtab_cnt--;
        end
        if (mshr_cnt > 0) begin
            mshr_cnt--;
        end
        #1;
        dir_check_nline_hit_way_i = hit;
        dir_check_nline_dirty_i   = hit_dirty;
        dir_check_entry_valid_i   = ent_valid;
        dir_check_entry_dirty_i   = ent_dirty;
        dir_check_entry_tag_i     = ent_tag;
        wbuf_empty_i              = (wbuf_cnt == 0);
        rtab_empty_i              = (rtab_cnt == 0);
        mshr_empty_i              = (mshr_cnt == 0);
        flush_alloc_ready_i       = !(stall_en && ($urandom % 10 < 3));
        core_rsp_ready_i          = !(stall_en && ($urandom % 10 < 3));
    endtask

    task automatic preload(input int kind, input set_t line_set, input tag_t line_tag);
        if (kind == PRE_KEEP) begin
            return;
        end
        for (int s = 0; s < CMO_SETS; s++) begin
            for (int w = 0; w < CMO_WAYS; w++) begin
                dir_valid[s][w] = (kind == PRE_RAND) ? 1'($urandom % 2) : 1'b1;
                dir_dirty[s][w] = (kind == PRE_RAND) ? 1'($urandom % 2) : (kind == PRE_DIRTY);
                dir_tag[s][w]   = tag_t'(24'h5a0000 | (s << 8) | (w << 4));
            end
        end
        // Target line sits in the last way
        if (kind == PRE_LINE) begin
            dir_tag[line_set][CMO_WAYS-1]   = line_tag;
            dir_dirty[line_set][CMO_WAYS-1] = 1'b1;
        end
    endtask

    task automatic run_row(input row_t r);
        set_t     line_set;
        tag_t     line_tag;
        way_vec_t exp_hit;
        int       cycles;
        logic     done;
        line_set = r.addr[CMO_OFFSET_W +: CMO_SET_W];
        line_tag = r.addr[CMO_ADDR_W-1 -: CMO_TAG_W];
        preload(r.preload, line_set, line_tag);
        exp_hit = '0;
        for (int w = 0; w < CMO_WAYS; w++) begin
            exp_hit[w] = dir_valid[line_set][w] && (dir_tag[line_set][w] == line_tag);
        end
        // Write-back order is set-major, then way
        exp_nline_q.delete();
        exp_way_q.delete();
        for (int s = 0; s < CMO_SETS; s++) begin
            for (int w = 0; w < CMO_WAYS; w++) begin
                if (dir_valid[s][w] && dir_dirty[s][w]) begin
                    exp_nline_q.push_back({dir_tag[s][w], set_t'(s)});
                    exp_way_q.push_back(way_vec_t'(1 << w));
                end
            end
        end
        flush_nline_q.delete();
        flush_way_q.delete();
        inval_set_q.delete();
        inval_way_q.delete();
        rsp_seen         = 1'b0;
        early_rsp        = 1'b0;
        rsp_count        = 0;
        early_strobes    = 0;
        wait_cycles      = 0;
        flush_all_cycles = 0;
        wbuf_cnt         = r.wbuf_n;
        rtab_cnt         = r.rtab_n;
        mshr_cnt         = r.mshr_n;
        stall_en         = r.stall;
        tick();

        req_valid_i    = 1'b1;
        req_op_i       = r.op;
        req_addr_i     = r.addr;
        req_tid_i      = r.tid;
        req_need_rsp_i = r.need_rsp;
        accepted       = 1'b0;
        cycles         = 0;
        while (!accepted && cycles < TIMEOUT) begin
            tick();
            cycles++;
        end
        req_valid_i = 1'b0;
        if (!accepted) begin
            $display("timeout: %s request was never accepted", r.name);
            timeout_count++;
            return;
        end

        done   = 1'b0;
        cycles = 0;
        while (!done && cycles < TIMEOUT) begin
            tick();
            cycles++;
            done = r.need_rsp ? (rsp_count > 0) : ready_seen;
        end
        if (!done) begin
            $display("timeout: %s operation did not complete", r.name);
            timeout_count++;
            return;
        end
        repeat (3) tick();

        compare(r.name, "responses", r.need_rsp ? 1 : 0, rsp_count);
        if (r.need_rsp) begin
            compare(r.name, "tid", r.tid, rsp_tid);
        end
        compare(r.name, "invalidations", r.exp_invals, inval_set_q.size());
        case (r.op)
            CMO_FENCE: begin
                compare(r.name, "flush all seen", 1, flush_all_cycles > 0);
                compare(r.name, "response before empty", 0, early_rsp);
            end
            CMO_INVAL_NLINE: begin
                compare(r.name, "strobes while busy", 0, early_strobes);
                if (r.mshr_n > 0) begin
                    compare(r.name, "wait seen", 1, wait_cycles > 0);
                end
                if (r.exp_invals == 1 && inval_set_q.size() == 1) begin
                    compare(r.name, "inval set", line_set, inval_set_q[0]);
                    compare(r.name, "inval way", exp_hit, inval_way_q[0]);
                end
                compare(r.name, "line still valid", 0, line_valid(line_set, line_tag));
            end
            CMO_INVAL_ALL: begin
                for (int k = 0; k < inval_set_q.size(); k++) begin
                    compare(r.name, "inval set", k, inval_set_q[k]);
                    compare(r.name, "inval way", {CMO_WAYS{1'b1}}, inval_way_q[k]);
                end
                compare(r.name, "valid entries", 0, valid_count());
            end
            default: begin
                compare(r.name, "flush count", exp_nline_q.size(), flush_nline_q.size());
                for (int k = 0; k < exp_nline_q.size() && k < flush_nline_q.size(); k++) begin
                    compare(r.name, "flush nline", exp_nline_q[k], flush_nline_q[k]);
                    compare(r.name, "flush way", exp_way_q[k], flush_way_q[k]);
                end
                compare(r.name, "transfers before response", exp_nline_q.size(), flush_at_rsp);
            end
        endcase
    endtask

    initial begin
        void'($urandom(56));
        rst_ni                    = 1'b0;
        wbuf_empty_i              = 1'b1;
        mshr_empty_i              = 1'b1;
        rtab_empty_i              = 1'b1;
        req_valid_i               = 1'b0;
        req_op_i                  = CMO_FENCE;
        req_addr_i                = '0;
        req_tid_i                 = '0;
        req_need_rsp_i            = 1'b0;
        core_rsp_ready_i          = 1'b1;
        dir_check_nline_hit_way_i = '0;
        dir_check_nline_dirty_i   = 1'b0;
        dir_check_entry_valid_i   = 1'b0;
        dir_check_entry_dirty_i   = 1'b0;
        dir_check_entry_tag_i     = '0;
        flush_alloc_ready_i       = 1'b1;
        stall_en                  = 1'b0;
        wbuf_cnt                  = 0;
        rtab_cnt                  = 0;
        mshr_cnt                  = 0;
        err_count                 = 0;
        timeout_count             = 0;
        rsp_seen                  = 1'b0;

        // name, op, addr, tid, need_rsp, preload, wbuf, rtab, mshr, stall, invals
        rows[0] = '{"fence_quick", CMO_FENCE, 32'h0, 4'h1, 1'b1, PRE_DIRTY, 0, 0, 0, 1'b0, 0};
        rows[1] = '{"fence_busy", CMO_FENCE, 32'h0, 4'h3, 1'b1, PRE_KEEP, 4, 3, 0, 1'b0, 0};
        rows[2] = '{"fence_no_rsp", CMO_FENCE, 32'h0, 4'h5, 1'b0, PRE_KEEP, 2, 0, 0, 1'b0, 0};
        rows[3] = '{"inval_hit", CMO_INVAL_NLINE, 32'h0012_34c0, 4'h7, 1'b1, PRE_LINE,
                    0, 0, 0, 1'b0, 1};
        rows[4] = '{"inval_miss", CMO_INVAL_NLINE, 32'h0012_34c0, 4'h8, 1'b1, PRE_KEEP,
                    0, 0, 0, 1'b0, 0};
        rows[5] = '{"inval_all", CMO_INVAL_ALL, 32'h0, 4'h9, 1'b1, PRE_DIRTY,
                    0, 0, 0, 1'b0, CMO_SETS};
        rows[6] = '{"flush_random", CMO_FLUSH_ALL, 32'h0, 4'ha, 1'b1, PRE_RAND,
                    0, 0, 0, 1'b0, 0};
        rows[7] = '{"flush_stall", CMO_FLUSH_ALL, 32'h0, 4'hb, 1'b1, PRE_DIRTY,
                    0, 0, 0, 1'b1, 0};
        rows[8] = '{"wait_empty", CMO_INVAL_NLINE, 32'h0000_ab80, 4'hc, 1'b1, PRE_LINE,
                    0, 0, 6, 1'b0, 1};

        repeat (2) tick();
        rst_ni = 1'b1;

        for (int i = 0; i < NUM_ROWS && timeout_count == 0; i++) begin
            run_row(rows[i]);
        end

        // Failed bound assertions count as errors too
        err_count += uut.u_assertions.fail_count;
        $display("errors: %0d, timeouts: %0d", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: compile.f
rtl/cmo_pkg.sv
rtl/cmo_set_way_walker.sv
rtl/cmo_flush_queue.sv
rtl/cmo_sequencer.sv
rtl/cmo_top.sv
testbench/tb_cmo_assertions.sv
testbench/tb_cmo.sv

// File: Makefile
# Verilator flow for the cache maintenance handler

VERILATOR ?= verilator
FILELIST  ?= compile.f
TB_TOP    ?= tb_cmo
RTL_TOP   ?= cmo_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= sim passed
FAIL_MSG  ?= sim failed
RTL_SRCS  := $(shell grep '^rtl/' $(FILELIST))

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)

sim: build
	./$(BUILD_DIR)/V$(TB_TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
